/* common/display_pkg.sv */
// frame geometry defaults, address-width helpers and the Wishbone register map.
// the 32-bit data bus limits BYTES_PER_PIXEL to at most 4.
`default_nettype none

package display_pkg;

    // default frame geometry, overridden from the top level.
    localparam int BYTES_PER_PIXEL = 3;
    localparam int PIXEL_WIDTH = 16;
    localparam int PIXEL_HEIGHT = 12;

    // bits needed for a column address. WIDTH and HEIGHT registers carry one bit more
    // so that a full-frame extent fits.
    function automatic int column_bits(input int width);
        return (width > 1) ? $clog2(width) : 1;
    endfunction

    function automatic int row_bits(input int height);
        return (height > 1) ? $clog2(height) : 1;
    endfunction

    // never below one bit, even for a single byte per pixel.
    function automatic int byte_sel_bits(input int bytes_per_pixel);
        return (bytes_per_pixel > 1) ? $clog2(bytes_per_pixel) : 1;
    endfunction

    // Wishbone word addresses.
    localparam logic [2:0] REG_X1 = 3'd0;
    localparam logic [2:0] REG_Y1 = 3'd1;
    localparam logic [2:0] REG_WIDTH = 3'd2;
    localparam logic [2:0] REG_HEIGHT = 3'd3;
    localparam logic [2:0] REG_COLOR = 3'd4;
    localparam logic [2:0] REG_CONTROL = 3'd5;
    localparam logic [2:0] REG_STATUS = 3'd6;

    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_ACK_BIT = 1;

    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

endpackage

`default_nettype wire

/* source/fill_regs.sv */
// Wishbone classic slave for the fill registers; one ack per access, no wait states.
// CONTROL reads as zero and only turns writes into one-cycle start and ack pulses.
`timescale 1ns/1ps
`default_nettype none

module fill_regs #(
    parameter int BYTES_PER_PIXEL = display_pkg::BYTES_PER_PIXEL,
    parameter int PIXEL_WIDTH = display_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = display_pkg::PIXEL_HEIGHT
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic wb_cyc,
    input  wire logic wb_stb,
    input  wire logic wb_we,
    input  wire logic [2:0] wb_adr,
    input  wire logic [31:0] wb_dat_w,
    input  wire logic busy,
    input  wire logic done,
    output logic wb_ack,
    output logic [31:0] wb_dat_r,
    output logic start,
    output logic ack,
    output logic [display_pkg::column_bits(PIXEL_WIDTH)-1:0] x1,
    output logic [display_pkg::row_bits(PIXEL_HEIGHT)-1:0] y1,
    output logic [display_pkg::column_bits(PIXEL_WIDTH):0] width,
    output logic [display_pkg::row_bits(PIXEL_HEIGHT):0] height,
    output logic [BYTES_PER_PIXEL*8-1:0] color
);
    import display_pkg::*;

    localparam int COL_W = column_bits(PIXEL_WIDTH);
    localparam int ROW_W = row_bits(PIXEL_HEIGHT);
    localparam int COLOR_W = BYTES_PER_PIXEL * 8;

    logic access;
    logic write;
    logic control_write;
    logic [31:0] read_word;

    // the ack goes out one cycle after a new strobe. The !wb_ack term keeps the
    // cycle in which the host is still dropping its strobe from starting a second access.
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign write = access && wb_we;
    assign control_write = write && (wb_adr == REG_CONTROL);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            start <= 1'b0;
            ack <= 1'b0;
            x1 <= '0;
            y1 <= '0;
            width <= '0;
            height <= '0;
            color <= '0;
        end else begin
            wb_ack <= access;
            start <= control_write && wb_dat_w[CTRL_START_BIT];
            ack <= control_write && wb_dat_w[CTRL_ACK_BIT];
            if (write) begin
                case (wb_adr)
                    REG_X1: x1 <= wb_dat_w[COL_W-1:0];
                    REG_Y1: y1 <= wb_dat_w[ROW_W-1:0];
                    REG_WIDTH: width <= wb_dat_w[COL_W:0];
                    REG_HEIGHT: height <= wb_dat_w[ROW_W:0];
                    REG_COLOR: color <= wb_dat_w[COLOR_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // read data is zero-extended from the implemented register widths.
    always_comb begin
        read_word = '0;
        case (wb_adr)
            REG_X1: read_word = 32'(x1);
            REG_Y1: read_word = 32'(y1);
            REG_WIDTH: read_word = 32'(width);
            REG_HEIGHT: read_word = 32'(height);
            REG_COLOR: read_word = 32'(color);
            REG_STATUS: begin
                read_word[STAT_BUSY_BIT] = busy;
                read_word[STAT_DONE_BIT] = done;
            end
            default: read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= read_word;
        end
    end

    // the host keeps its strobe up until it has seen the ack.
    a_ack_inside_cycle: assert property (
        @(posedge clk) disable iff (reset) wb_ack |-> (wb_cyc && wb_stb)
    );

endmodule

`default_nettype wire

/* fillarea/fillarea_engine.sv */
// rectangle fill, one byte per clock from the bottom-right pixel back to the top-left.
// no clipping: width and height are at least 1 and the rectangle lies inside the frame.
`timescale 1ns/1ps
`default_nettype none

module fillarea_engine #(
    parameter int BYTES_PER_PIXEL = display_pkg::BYTES_PER_PIXEL,
    parameter int PIXEL_WIDTH = display_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = display_pkg::PIXEL_HEIGHT
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    input  wire logic ack,
    input  wire logic [display_pkg::column_bits(PIXEL_WIDTH)-1:0] x1,
    input  wire logic [display_pkg::row_bits(PIXEL_HEIGHT)-1:0] y1,
    input  wire logic [display_pkg::column_bits(PIXEL_WIDTH):0] width,
    input  wire logic [display_pkg::row_bits(PIXEL_HEIGHT):0] height,
    input  wire logic [BYTES_PER_PIXEL*8-1:0] color,
    output logic write_enable,
    output logic [display_pkg::row_bits(PIXEL_HEIGHT)-1:0] row,
    output logic [display_pkg::column_bits(PIXEL_WIDTH)-1:0] column,
    output logic [display_pkg::byte_sel_bits(BYTES_PER_PIXEL)-1:0] byte_sel,
    output logic [7:0] data_out,
    output logic busy,
    output logic done
);
    import display_pkg::*;

    localparam int COL_W = column_bits(PIXEL_WIDTH);
    localparam int ROW_W = row_bits(PIXEL_HEIGHT);
    localparam int SEL_W = byte_sel_bits(BYTES_PER_PIXEL);
    localparam logic [SEL_W-1:0] TOP_SEL = SEL_W'(BYTES_PER_PIXEL - 1);

    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_FILL,
        STATE_DONE
    } fill_state_t;

    fill_state_t state;

    // operands held for the whole fill, so register writes meanwhile do no harm.
    logic [COL_W-1:0] x1_q;
    logic [ROW_W-1:0] y1_q;
    logic [COL_W-1:0] col_last_q;
    logic [BYTES_PER_PIXEL*8-1:0] color_q;

    logic [COL_W:0] x_end;
    logic [ROW_W:0] y_end;
    logic accept;
    logic last_byte;
    logic [SEL_W-1:0] next_sel;

    assign x_end = {1'b0, x1} + width;
    assign y_end = {1'b0, y1} + height;
    assign accept = start && (state == STATE_IDLE);
    assign last_byte = (row == y1_q) && (column == x1_q) && (byte_sel == '0);
    assign next_sel = (byte_sel == '0) ? TOP_SEL : byte_sel - 1'b1;

    assign write_enable = (state == STATE_FILL);
    assign busy = (state == STATE_FILL);
    assign done = (state == STATE_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= STATE_IDLE;
        end else begin
            case (state)
                STATE_IDLE: if (accept) state <= STATE_FILL;
                STATE_FILL: if (last_byte) state <= STATE_DONE;
                STATE_DONE: if (ack) state <= STATE_IDLE;
                default: state <= STATE_IDLE;
            endcase
        end
    end

    // the first write address and byte are loaded on the start edge itself.
    always_ff @(posedge clk) begin
        if (accept) begin
            x1_q <= x1;
            y1_q <= y1;
            col_last_q <= COL_W'(x_end - 1'b1);
            color_q <= color;
            row <= ROW_W'(y_end - 1'b1);
            column <= COL_W'(x_end - 1'b1);
            byte_sel <= TOP_SEL;
            data_out <= color[8*(BYTES_PER_PIXEL-1) +: 8];
        end else if ((state == STATE_FILL) && !last_byte) begin
            byte_sel <= next_sel;
            data_out <= color_q[8*int'(next_sel) +: 8];
            if (byte_sel == '0) begin
                if (column == x1_q) begin
                    column <= col_last_q;
                    row <= row - 1'b1;
                end else begin
                    column <= column - 1'b1;
                end
            end
        end
    end

    // the frame memory has no bounds check of its own.
    a_write_in_frame: assert property (
        @(posedge clk) disable iff (reset)
        write_enable |-> (row < PIXEL_HEIGHT) && (column < PIXEL_WIDTH)
                         && (byte_sel < BYTES_PER_PIXEL)
    );

    // the walk never leaves the rectangle captured at the start.
    a_write_in_rectangle: assert property (
        @(posedge clk) disable iff (reset)
        write_enable |-> (row >= y1_q) && (column >= x1_q) && (column <= col_last_q)
    );

endmodule

`default_nettype wire

/* fillarea/frame_memory.sv */
// byte-wide frame RAM, one write and one registered read port per clock.
// contents are not cleared by reset.
`timescale 1ns/1ps
`default_nettype none

module frame_memory #(
    parameter int BYTES_PER_PIXEL = display_pkg::BYTES_PER_PIXEL,
    parameter int PIXEL_WIDTH = display_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = display_pkg::PIXEL_HEIGHT
) (
    input  wire logic clk,
    input  wire logic write_enable,
    input  wire logic [display_pkg::row_bits(PIXEL_HEIGHT)-1:0] row,
    input  wire logic [display_pkg::column_bits(PIXEL_WIDTH)-1:0] column,
    input  wire logic [display_pkg::byte_sel_bits(BYTES_PER_PIXEL)-1:0] byte_sel,
    input  wire logic [7:0] data_in,
    input  wire logic [display_pkg::row_bits(PIXEL_HEIGHT)-1:0] rd_row,
    input  wire logic [display_pkg::column_bits(PIXEL_WIDTH)-1:0] rd_column,
    input  wire logic [display_pkg::byte_sel_bits(BYTES_PER_PIXEL)-1:0] rd_byte_sel,
    output logic [7:0] rd_data
);
    import display_pkg::*;

    localparam int COL_W = column_bits(PIXEL_WIDTH);
    localparam int ROW_W = row_bits(PIXEL_HEIGHT);
    localparam int SEL_W = byte_sel_bits(BYTES_PER_PIXEL);
    localparam int DEPTH = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [7:0] mem [DEPTH];
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // pixels are stored row by row, the bytes of a pixel at consecutive addresses.
    function automatic logic [ADDR_W-1:0] byte_address(
        input logic [ROW_W-1:0] r,
        input logic [COL_W-1:0] c,
        input logic [SEL_W-1:0] sel
    );
        logic [ADDR_W-1:0] pixel_index;
        pixel_index = ADDR_W'(r) * ADDR_W'(PIXEL_WIDTH) + ADDR_W'(c);
        return pixel_index * ADDR_W'(BYTES_PER_PIXEL) + ADDR_W'(sel);
    endfunction

    assign wr_addr = byte_address(row, column, byte_sel);
    assign rd_addr = byte_address(rd_row, rd_column, rd_byte_sel);

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[wr_addr] <= data_in;
        end
    end

    // read-before-write: a byte written on the same edge reads back its old value.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* source/display_top.sv */
// framebuffer subsystem: Wishbone fill registers, rectangle-fill engine and frame RAM.
// geometry is set here and passed down to every block.
`timescale 1ns/1ps
`default_nettype none

module display_top #(
    parameter int BYTES_PER_PIXEL = display_pkg::BYTES_PER_PIXEL,
    parameter int PIXEL_WIDTH = display_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = display_pkg::PIXEL_HEIGHT
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic wb_cyc,
    input  wire logic wb_stb,
    input  wire logic wb_we,
    input  wire logic [2:0] wb_adr,
    input  wire logic [31:0] wb_dat_w,
    output logic wb_ack,
    output logic [31:0] wb_dat_r,
    input  wire logic [display_pkg::row_bits(PIXEL_HEIGHT)-1:0] rd_row,
    input  wire logic [display_pkg::column_bits(PIXEL_WIDTH)-1:0] rd_column,
    input  wire logic [display_pkg::byte_sel_bits(BYTES_PER_PIXEL)-1:0] rd_byte_sel,
    output logic [7:0] rd_data
);
    import display_pkg::*;

    localparam int COL_W = column_bits(PIXEL_WIDTH);
    localparam int ROW_W = row_bits(PIXEL_HEIGHT);
    localparam int SEL_W = byte_sel_bits(BYTES_PER_PIXEL);

    logic start;
    logic ack;
    logic busy;
    logic done;
    logic [COL_W-1:0] x1;
    logic [ROW_W-1:0] y1;
    logic [COL_W:0] width;
    logic [ROW_W:0] height;
    logic [BYTES_PER_PIXEL*8-1:0] color;

    logic write_enable;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] column;
    logic [SEL_W-1:0] byte_sel;
    logic [7:0] fill_data;

    fill_regs #(
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL),
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT)
    ) u_fill_regs (
        .clk(clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .busy(busy),
        .done(done),
        .wb_ack(wb_ack),
        .wb_dat_r(wb_dat_r),
        .start(start),
        .ack(ack),
        .x1(x1),
        .y1(y1),
        .width(width),
        .height(height),
        .color(color)
    );

    fillarea_engine #(
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL),
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT)
    ) u_fillarea_engine (
        .clk(clk),
        .reset(reset),
        .start(start),
        .ack(ack),
        .x1(x1),
        .y1(y1),
        .width(width),
        .height(height),
        .color(color),
        .write_enable(write_enable),
        .row(row),
        .column(column),
        .byte_sel(byte_sel),
        .data_out(fill_data),
        .busy(busy),
        .done(done)
    );

    frame_memory #(
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL),
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT)
    ) u_frame_memory (
        .clk(clk),
        .write_enable(write_enable),
        .row(row),
        .column(column),
        .byte_sel(byte_sel),
        .data_in(fill_data),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_byte_sel(rd_byte_sel),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

/* sim/tb_display_top.sv */
// self-checking testbench for display_top with a byte model of the whole frame.
// random operands come from a fixed seed, so every run repeats the same fills.
`timescale 1ns/1ps
`default_nettype none

module tb_display_top;
    import display_pkg::*;

    localparam int COL_W = (PIXEL_WIDTH > 1) ? $clog2(PIXEL_WIDTH) : 1;
    localparam int ROW_W = (PIXEL_HEIGHT > 1) ? $clog2(PIXEL_HEIGHT) : 1;
    localparam int SEL_W = (BYTES_PER_PIXEL > 1) ? $clog2(BYTES_PER_PIXEL) : 1;
    localparam int FRAME_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam logic [31:0] COLOR_MASK = 32'((64'd1 << (8 * BYTES_PER_PIXEL)) - 64'd1);
    localparam int RANDOM_FILLS = 20;
    // every fill costs at most a full-frame fill, a readback at two cycles per byte
    // and some register traffic. The extra fill covers the reset checks.
    localparam int FILL_COUNT = RANDOM_FILLS + 4;
    localparam int CYCLES_PER_FILL = FRAME_BYTES + 2 * FRAME_BYTES + 100;
    localparam int TIMEOUT_NS = FILL_COUNT * CYCLES_PER_FILL * 40 * 2;

    logic clk = 1'b0;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [2:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic wb_ack;
    logic [31:0] wb_dat_r;
    logic [ROW_W-1:0] rd_row;
    logic [COL_W-1:0] rd_column;
    logic [SEL_W-1:0] rd_byte_sel;
    logic [7:0] rd_data;

    logic [7:0] model [FRAME_BYTES];
    integer seed;
    int error_count;
    int check_count;

    display_top u_dut (
        .clk(clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_ack(wb_ack),
        .wb_dat_r(wb_dat_r),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_byte_sel(rd_byte_sel),
        .rd_data(rd_data)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: expected 0x%h, actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic pick_below(input int unsigned n, output int unsigned value);
        value = $unsigned($random(seed)) % n;
    endtask

    // pixels are stored row by row with the bytes of a pixel next to each other.
    function automatic int byte_index(input int r, input int c, input int k);
        return (r * PIXEL_WIDTH + c) * BYTES_PER_PIXEL + k;
    endfunction

    function automatic logic [31:0] register_mask(input logic [2:0] adr);
        case (adr)
            REG_X1: return 32'((1 << COL_W) - 1);
            REG_Y1: return 32'((1 << ROW_W) - 1);
            REG_WIDTH: return 32'((1 << (COL_W + 1)) - 1);
            REG_HEIGHT: return 32'((1 << (ROW_W + 1)) - 1);
            REG_COLOR: return COLOR_MASK;
            default: return 32'h0;
        endcase
    endfunction

    // the strobe goes out on a rising edge and the slave answers on the next one,
    // so the ack shows at the second falling edge.
    task automatic wait_for_ack();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack);
        check_value("wb_ack latency", 32'd2, 32'(waited));
    endtask

    // Wishbone classic: hold the request until ack, then drop the strobe for a cycle.
    task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= adr;
        wb_dat_w <= data;
        wait_for_ack();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        // the ack lasts one cycle.
        @(negedge clk);
        check_value("wb_ack", 32'h0, 32'(wb_ack));
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= adr;
        wait_for_ack();
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(negedge clk);
        check_value("wb_ack", 32'h0, 32'(wb_ack));
    endtask

    task automatic read_frame_byte(input int r, input int c, input int k,
                                   output logic [7:0] value);
        @(posedge clk);
        rd_row <= ROW_W'(r);
        rd_column <= COL_W'(c);
        rd_byte_sel <= SEL_W'(k);
        @(posedge clk);
        @(negedge clk);
        value = rd_data;
    endtask

    task automatic compare_frame();
        logic [7:0] value;
        for (int r = 0; r < PIXEL_HEIGHT; r++) begin
            for (int c = 0; c < PIXEL_WIDTH; c++) begin
                for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
                    read_frame_byte(r, c, k, value);
                    check_value($sformatf("rd_data (row %0d, column %0d, byte %0d)", r, c, k),
                                32'(model[byte_index(r, c, k)]), 32'(value));
                end
            end
        end
    endtask

    task automatic paint_model(input int x, input int y, input int w, input int h,
                               input logic [31:0] color);
        for (int r = y; r < y + h; r++) begin
            for (int c = x; c < x + w; c++) begin
                for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
                    model[byte_index(r, c, k)] = color[8*k +: 8];
                end
            end
        end
    endtask

    task automatic start_fill(input int x, input int y, input int w, input int h,
                              input logic [31:0] color);
        bus_write(REG_X1, 32'(x));
        bus_write(REG_Y1, 32'(y));
        bus_write(REG_WIDTH, 32'(w));
        bus_write(REG_HEIGHT, 32'(h));
        bus_write(REG_COLOR, color);
        bus_write(REG_CONTROL, 32'(1) << CTRL_START_BIT);
    endtask

    // the first status read lands a few cycles after the start, inside any fill of
    // four bytes or more.
    task automatic wait_for_done(input int bytes);
        logic [31:0] status;
        bus_read(REG_STATUS, status);
        if (bytes >= 4) begin
            check_value("STATUS while filling", 32'(1) << STAT_BUSY_BIT, status);
        end
        while (!status[STAT_DONE_BIT]) begin
            bus_read(REG_STATUS, status);
        end
        check_value("STATUS after fill", 32'(1) << STAT_DONE_BIT, status);
    endtask

    task automatic acknowledge_fill();
        logic [31:0] status;
        bus_write(REG_CONTROL, 32'(1) << CTRL_ACK_BIT);
        bus_read(REG_STATUS, status);
        check_value("STATUS after ack", 32'h0, status);
    endtask

    task automatic run_fill(input int x, input int y, input int w, input int h,
                            input logic [31:0] color);
        start_fill(x, y, w, h, color);
        wait_for_done(w * h * BYTES_PER_PIXEL);
        acknowledge_fill();
        paint_model(x, y, w, h, color);
        compare_frame();
    endtask

    task automatic random_rectangle(output int x, output int y, output int w, output int h);
        int unsigned value;
        pick_below(PIXEL_WIDTH, value);
        x = int'(value);
        pick_below(PIXEL_HEIGHT, value);
        y = int'(value);
        pick_below(PIXEL_WIDTH - x, value);
        w = 1 + int'(value);
        pick_below(PIXEL_HEIGHT - y, value);
        h = 1 + int'(value);
    endtask

    task automatic check_reset_state();
        logic [31:0] value;
        logic [31:0] data;
        logic [2:0] adr;
        bus_read(REG_STATUS, value);
        check_value("STATUS after reset", 32'h0, value);
        for (int a = REG_X1; a <= REG_COLOR; a++) begin
            adr = 3'(a);
            bus_read(adr, value);
            check_value($sformatf("register %0d after reset", a), 32'h0, value);
            data = $random(seed);
            bus_write(adr, data);
            bus_read(adr, value);
            check_value($sformatf("register %0d readback", a), data & register_mask(adr), value);
        end
        bus_read(REG_CONTROL, value);
        check_value("CONTROL readback", 32'h0, value);
    endtask

    // a second start while done is pending must be dropped without a write.
    task automatic check_pending_start();
        int x;
        int y;
        int w;
        int h;
        logic [31:0] value;
        logic [31:0] color;
        random_rectangle(x, y, w, h);
        color = $random(seed) & COLOR_MASK;
        start_fill(x, y, w, h, color);
        wait_for_done(w * h * BYTES_PER_PIXEL);
        paint_model(x, y, w, h, color);
        start_fill(0, 0, PIXEL_WIDTH, PIXEL_HEIGHT, $random(seed) & COLOR_MASK);
        repeat (3) begin
            bus_read(REG_STATUS, value);
            check_value("STATUS with start pending", 32'(1) << STAT_DONE_BIT, value);
        end
        compare_frame();
        acknowledge_fill();
    endtask

    task automatic check_operand_hold();
        int unsigned value;
        int x;
        int y;
        logic [31:0] color;
        pick_below(PIXEL_WIDTH / 2, value);
        x = int'(value);
        pick_below(PIXEL_HEIGHT / 2, value);
        y = int'(value);
        color = $random(seed) & COLOR_MASK;
        start_fill(x, y, PIXEL_WIDTH - x, PIXEL_HEIGHT - y, color);
        bus_write(REG_X1, 32'(PIXEL_WIDTH - 1 - x));
        bus_write(REG_COLOR, ~color & COLOR_MASK);
        wait_for_done((PIXEL_WIDTH - x) * (PIXEL_HEIGHT - y) * BYTES_PER_PIXEL);
        acknowledge_fill();
        paint_model(x, y, PIXEL_WIDTH - x, PIXEL_HEIGHT - y, color);
        compare_frame();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        error_count++;
        end_run();
    end

    initial begin
        int x;
        int y;
        int w;
        int h;
        seed = 32'h5b7765f1;
        error_count = 0;
        check_count = 0;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 3'd0;
        wb_dat_w = 32'h0;
        rd_row = '0;
        rd_column = '0;
        rd_byte_sel = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        check_reset_state();
        // the memory has no reset, so the first fill sets every byte.
        run_fill(0, 0, PIXEL_WIDTH, PIXEL_HEIGHT, $random(seed) & COLOR_MASK);
        check_pending_start();
        check_operand_hold();
        for (int i = 0; i < RANDOM_FILLS; i++) begin
            random_rectangle(x, y, w, h);
            run_fill(x, y, w, h, $random(seed) & COLOR_MASK);
        end
        end_run();
    end

endmodule

`default_nettype wire

/* all.f */
common/display_pkg.sv
source/fill_regs.sv
fillarea/fillarea_engine.sv
fillarea/frame_memory.sv
source/display_top.sv
sim/tb_display_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_display_top -f all.f > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/Vtb_display_top > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0
